/* hdl/ddc_pkg.sv */
package ddc_pkg;

    // Channel count and index width
    localparam int n_ch     = 4;
    localparam int ch_idx_w = $clog2(n_ch);

    // Sample, accumulator and length widths
    localparam int ddc_w    = 32;
    localparam int acc_w    = 48;
    localparam int len_w    = 16;

    // One output beat carries Q above I
    localparam int beat_w   = 2 * acc_w;

    typedef logic signed [ddc_w-1:0] ddc_sample_t;

    typedef logic signed [acc_w-1:0] acc_sum_t;

    typedef logic [len_w-1:0] acc_len_t;

    typedef logic [ch_idx_w-1:0] ch_idx_t;

    typedef logic [beat_w-1:0] ddc_beat_t;

endpackage

/* hdl/dump_timer.sv */
`timescale 1ns/1ns

module dump_timer
    import ddc_pkg::*;
(
    input  logic     s_axis_aclk,
    input  logic     s_axis_aresetn,
    input  logic     s_axis_ddc_tvalid,
    input  acc_len_t acc_len,
    input  logic     resync,
    output logic     frame_start,
    output logic     frame_last
);

    acc_len_t strobe_cnt;
    acc_len_t frame_len;
    acc_len_t cur_len;
    logic     at_start;

    // Count of zero means the next strobe opens a frame
    assign at_start = (strobe_cnt == '0);

    // First strobe sees the live length, the rest use the captured copy
    assign cur_len = at_start ? acc_len : frame_len;

    assign frame_start = s_axis_ddc_tvalid && at_start;
    assign frame_last  = s_axis_ddc_tvalid && (strobe_cnt == cur_len - acc_len_t'(1));

    // Strobe counter
    always_ff @(posedge s_axis_aclk) begin
        if (!s_axis_aresetn) begin
            strobe_cnt <= '0;
        end else if (resync) begin
            strobe_cnt <= '0;
        end else if (frame_last) begin
            // Wrap after the final strobe of the frame
            strobe_cnt <= '0;
        end else if (s_axis_ddc_tvalid) begin
            strobe_cnt <= strobe_cnt + acc_len_t'(1);
        end
    end

    // Length is held for the rest of the frame
    always_ff @(posedge s_axis_aclk) begin
        if (frame_start) begin
            frame_len <= acc_len;
        end
    end

endmodule

/* hdl/iq_integrator.sv */
`timescale 1ns/1ns

module iq_integrator
    import ddc_pkg::*;
(
    input  logic        s_axis_aclk,
    input  logic        s_axis_aresetn,
    input  ddc_sample_t sample_i,
    input  ddc_sample_t sample_q,
    input  logic        sample_valid,
    input  logic        frame_start,
    input  logic        frame_last,
    input  logic        resync,
    output acc_sum_t    sum_i,
    output acc_sum_t    sum_q,
    output logic        sum_valid
);

    acc_sum_t run_i;
    acc_sum_t run_q;
    acc_sum_t next_i;
    acc_sum_t next_q;

    // Sign extend and add; a frame start drops the old running value
    assign next_i = (frame_start ? acc_sum_t'(0) : run_i) +
                    {{(acc_w - ddc_w){sample_i[ddc_w-1]}}, sample_i};
    assign next_q = (frame_start ? acc_sum_t'(0) : run_q) +
                    {{(acc_w - ddc_w){sample_q[ddc_w-1]}}, sample_q};

    always_ff @(posedge s_axis_aclk) begin
        if (!s_axis_aresetn) begin
            run_i     <= '0;
            run_q     <= '0;
            sum_i     <= '0;
            sum_q     <= '0;
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= 1'b0;
            if (resync) begin
                // Partial frame is thrown away
                run_i <= '0;
                run_q <= '0;
            end else if (sample_valid && frame_last) begin
                sum_i     <= next_i;
                sum_q     <= next_q;
                sum_valid <= 1'b1;
                run_i     <= '0;
                run_q     <= '0;
            end else if (sample_valid) begin
                run_i <= next_i;
                run_q <= next_q;
            end
        end
    end

endmodule

/* hdl/channel_serializer.sv */
`timescale 1ns/1ns

module channel_serializer
    import ddc_pkg::*;
(
    input  logic                s_axis_aclk,
    input  logic                s_axis_aresetn,
    input  acc_sum_t [n_ch-1:0] sum_i,
    input  acc_sum_t [n_ch-1:0] sum_q,
    input  logic                sum_valid,
    input  logic                ddc_gate,
    output ddc_beat_t           m_axis_ddc_tdata,
    output logic                m_axis_ddc_tvalid
);

    acc_sum_t bank_i [n_ch];
    acc_sum_t bank_q [n_ch];
    ch_idx_t  rd_ch;
    logic     busy;
    logic     beat_valid;
    logic     last_ch;

    assign last_ch = (rd_ch == ch_idx_t'(n_ch - 1));

    // Snapshot of every channel at the dump
    always_ff @(posedge s_axis_aclk) begin
        if (sum_valid) begin
            for (int k = 0; k < n_ch; k++) begin
                bank_i[k] <= sum_i[k];
                bank_q[k] <= sum_q[k];
            end
        end
    end

    // Readout steps one channel per cycle
    always_ff @(posedge s_axis_aclk) begin
        if (!s_axis_aresetn) begin
            busy       <= 1'b0;
            rd_ch      <= '0;
            beat_valid <= 1'b0;
        end else begin
            beat_valid <= busy;
            if (sum_valid) begin
                busy  <= 1'b1;
                rd_ch <= '0;
            end else if (busy) begin
                rd_ch <= rd_ch + ch_idx_t'(1);
                if (last_ch) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // Output beat register
    always_ff @(posedge s_axis_aclk) begin
        if (busy) begin
            m_axis_ddc_tdata <= {bank_q[rd_ch], bank_i[rd_ch]};
        end
    end

    // Gate masks only the strobe and the readout runs on
    assign m_axis_ddc_tvalid = beat_valid & ddc_gate;

endmodule

/* hdl/ddc_readout.sv */
`timescale 1ns/1ns

module ddc_readout
    import ddc_pkg::*;
(
    input  logic                   s_axis_aclk,
    input  logic                   s_axis_aresetn,
    input  ddc_sample_t [n_ch-1:0] s_axis_ddc_i_tdata,
    input  ddc_sample_t [n_ch-1:0] s_axis_ddc_q_tdata,
    input  logic                   s_axis_ddc_tvalid,
    input  acc_len_t               acc_len,
    input  logic                   resync,
    input  logic                   ddc_gate,
    output ddc_beat_t              m_axis_ddc_tdata,
    output logic                   m_axis_ddc_tvalid
);

    logic                frame_start;
    logic                frame_last;
    acc_sum_t [n_ch-1:0] sum_i;
    acc_sum_t [n_ch-1:0] sum_q;
    logic     [n_ch-1:0] sum_valid;

    dump_timer dump_timer_i (
        .s_axis_aclk       (s_axis_aclk),
        .s_axis_aresetn    (s_axis_aresetn),
        .s_axis_ddc_tvalid (s_axis_ddc_tvalid),
        .acc_len           (acc_len),
        .resync            (resync),
        .frame_start       (frame_start),
        .frame_last        (frame_last)
    );

    // One integrator pair per channel, all on the shared frame marks
    for (genvar k = 0; k < n_ch; k++) begin : g_ch
        iq_integrator iq_integrator_i (
            .s_axis_aclk    (s_axis_aclk),
            .s_axis_aresetn (s_axis_aresetn),
            .sample_i       (s_axis_ddc_i_tdata[k]),
            .sample_q       (s_axis_ddc_q_tdata[k]),
            .sample_valid   (s_axis_ddc_tvalid),
            .frame_start    (frame_start),
            .frame_last     (frame_last),
            .resync         (resync),
            .sum_i          (sum_i[k]),
            .sum_q          (sum_q[k]),
            .sum_valid      (sum_valid[k])
        );
    end

    // Channel 0 dump strobe stands for all channels
    channel_serializer channel_serializer_i (
        .s_axis_aclk       (s_axis_aclk),
        .s_axis_aresetn    (s_axis_aresetn),
        .sum_i             (sum_i),
        .sum_q             (sum_q),
        .sum_valid         (sum_valid[0]),
        .ddc_gate          (ddc_gate),
        .m_axis_ddc_tdata  (m_axis_ddc_tdata),
        .m_axis_ddc_tvalid (m_axis_ddc_tvalid)
    );

endmodule

/* bench/ddc_readout_tb.sv */
`timescale 1ns/1ns

module ddc_readout_tb
    import ddc_pkg::*;
();

    logic                   s_axis_aclk;
    logic                   s_axis_aresetn;
    ddc_sample_t [n_ch-1:0] s_axis_ddc_i_tdata;
    ddc_sample_t [n_ch-1:0] s_axis_ddc_q_tdata;
    logic                   s_axis_ddc_tvalid;
    acc_len_t               acc_len;
    logic                   resync;
    logic                   ddc_gate;
    ddc_beat_t              m_axis_ddc_tdata;
    logic                   m_axis_ddc_tvalid;

    // Stimulus, one entry per golden line
    acc_len_t               stim_len [$];
    logic                   stim_gate [$];
    logic                   stim_rs [$];
    ddc_sample_t [n_ch-1:0] stim_i [$];
    ddc_sample_t [n_ch-1:0] stim_q [$];

    // Expected beats in arrival order
    ddc_beat_t              exp_beat [$];
    int                     exp_ch [$];
    string                  exp_name [$];

    logic [31:0] lfsr_state;
    int          cycle = 0;
    int          last_cycle = -10;
    int          value_errors = 0;
    int          order_errors = 0;
    int          timeout_errors = 0;
    int          file_errors = 0;

    ddc_readout dut_i (
        .s_axis_aclk        (s_axis_aclk),
        .s_axis_aresetn     (s_axis_aresetn),
        .s_axis_ddc_i_tdata (s_axis_ddc_i_tdata),
        .s_axis_ddc_q_tdata (s_axis_ddc_q_tdata),
        .s_axis_ddc_tvalid  (s_axis_ddc_tvalid),
        .acc_len            (acc_len),
        .resync             (resync),
        .ddc_gate           (ddc_gate),
        .m_axis_ddc_tdata   (m_axis_ddc_tdata),
        .m_axis_ddc_tvalid  (m_axis_ddc_tvalid)
    );

    initial begin
        s_axis_aclk = 1'b0;
        forever #2 s_axis_aclk = ~s_axis_aclk;
    end

    always @(posedge s_axis_aclk) begin
        cycle <= cycle + 1;
    end

    // Galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic take_bits(input int count, output int value);
        value = 0;
        for (int b = 0; b < count; b++) begin
            value = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic load_golden();
        int          fd;
        int          n;
        int          end_i;
        int          len_v;
        int          gate_v;
        int          rs_v;
        int          ch_v;
        string       line;
        string       rest;
        string       test_name;
        ddc_sample_t i0, q0, i1, q1, i2, q2, i3, q3;
        acc_sum_t    q_v;
        acc_sum_t    i_v;
        test_name = "unnamed";
        fd = $fopen("bench/ddc_readout_golden.txt", "r");
        assert (fd != 0) else begin
            $display("ERROR: cannot open bench/ddc_readout_golden.txt");
            file_errors++;
        end
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                end_i = line.len() - 1;
                if (end_i >= 0 && line[end_i] == 8'h0a) end_i--;
                if (end_i < 2 || line[0] == "#") continue;
                rest = line.substr(1, end_i);
                if (line[0] == "t") begin
                    test_name = line.substr(2, end_i);
                end else if (line[0] == "s") begin
                    n = $sscanf(rest, "%h %h %h %h %h %h %h %h %h %h %h", len_v, gate_v, rs_v,
                                i0, q0, i1, q1, i2, q2, i3, q3);
                    assert (n == 11) else begin
                        $display("ERROR: malformed stimulus line in golden file: %s", line);
                        file_errors++;
                    end
                    if (n == 11) begin
                        stim_len.push_back(acc_len_t'(len_v));
                        stim_gate.push_back(gate_v != 0);
                        stim_rs.push_back(rs_v != 0);
                        stim_i.push_back({i3, i2, i1, i0});
                        stim_q.push_back({q3, q2, q1, q0});
                    end
                end else if (line[0] == "e") begin
                    n = $sscanf(rest, "%h %h %h", ch_v, q_v, i_v);
                    assert (n == 3) else begin
                        $display("ERROR: malformed expected line in golden file: %s", line);
                        file_errors++;
                    end
                    if (n == 3) begin
                        exp_beat.push_back({q_v, i_v});
                        exp_ch.push_back(ch_v);
                        exp_name.push_back(test_name);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_idle();
        s_axis_ddc_tvalid = 1'b0;
        resync            = 1'b0;
    endtask

    // A resync line is a pulse on its own, without a strobe
    task automatic drive_line(input int n);
        acc_len            = stim_len[n];
        ddc_gate           = stim_gate[n];
        resync             = stim_rs[n];
        s_axis_ddc_tvalid  = !stim_rs[n];
        s_axis_ddc_i_tdata = stim_i[n];
        s_axis_ddc_q_tdata = stim_q[n];
    endtask

    task automatic check_beat();
        ddc_beat_t want;
        int        ch;
        string     name;
        assert (exp_beat.size() != 0) else begin
            $display("ERROR: valid beat %h arrived when no beat was expected", m_axis_ddc_tdata);
            order_errors++;
        end
        if (exp_beat.size() != 0) begin
            want = exp_beat.pop_front();
            ch   = exp_ch.pop_front();
            name = exp_name.pop_front();
            assert (m_axis_ddc_tdata === want) else begin
                $display("FAILED %s ch%0d: expected %h, actual %h", name, ch, want,
                         m_axis_ddc_tdata);
                value_errors++;
            end
            // Channels of one readout come back to back
            if (ch != 0) begin
                assert (cycle == last_cycle + 1) else begin
                    $display("ERROR: %s channel %0d beat came %0d cycles after the previous one",
                             name, ch, cycle - last_cycle);
                    order_errors++;
                end
            end
            last_cycle = cycle;
        end
    endtask

    // Outputs are settled by the falling edge
    always @(negedge s_axis_aclk) begin
        if (s_axis_aresetn && m_axis_ddc_tvalid) begin
            check_beat();
        end
    end

    initial begin : main_seq
        int idle;
        int waited;
        int total;
        s_axis_aresetn     = 1'b0;
        s_axis_ddc_i_tdata = '0;
        s_axis_ddc_q_tdata = '0;
        s_axis_ddc_tvalid  = 1'b0;
        acc_len            = acc_len_t'(n_ch);
        resync             = 1'b0;
        ddc_gate           = 1'b1;
        lfsr_state         = 32'hc954;
        load_golden();
        repeat (3) @(posedge s_axis_aclk);
        #1;
        s_axis_aresetn = 1'b1;
        for (int n = 0; n < stim_len.size(); n++) begin
            take_bits(2, idle);
            // Let a running readout finish before the gate moves
            if (stim_gate[n] != ddc_gate) idle += n_ch + 3;
            repeat (idle) begin
                @(posedge s_axis_aclk);
                #1;
                drive_idle();
            end
            @(posedge s_axis_aclk);
            #1;
            drive_line(n);
        end
        @(posedge s_axis_aclk);
        #1;
        drive_idle();
        waited = 0;
        while (exp_beat.size() != 0 && waited < 4 * n_ch + 16) begin
            @(posedge s_axis_aclk);
            waited++;
        end
        assert (exp_beat.size() == 0) else begin
            $display("ERROR: timeout, beat for channel %0d of %s never arrived (%0d missing)",
                     exp_ch[0], exp_name[0], exp_beat.size());
            timeout_errors++;
        end
        // Quiet tail catches stray beats
        repeat (n_ch + 4) @(posedge s_axis_aclk);
        total = value_errors + order_errors + timeout_errors + file_errors;
        $display("Errors: %0d value, %0d order, %0d timeout, %0d file", value_errors,
                 order_errors, timeout_errors, file_errors);
        if (total == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* bench/ddc_readout_golden.txt */
# s: acc_len gate resync i0 q0 i1 q1 i2 q2 i3 q3, hex, one strobe per line (resync 1: pulse only)
# e: channel q_sum i_sum, hex 48 bit, in arrival order; t: test name for the e lines after it
t basic_frames
s 4 1 0 00000001 00000010 00000100 00001000 00010000 00100000 01000000 10000000
s 4 1 0 00000002 00000020 00000200 00002000 00020000 00200000 02000000 20000000
s 4 1 0 00000003 00000030 00000300 00003000 00030000 00300000 03000000 30000000
s 4 1 0 00000004 00000040 00000400 00004000 00040000 00400000 04000000 40000000
e 0 0000000000a0 00000000000a
e 1 00000000a000 000000000a00
e 2 000000a00000 0000000a0000
e 3 0000a0000000 00000a000000
t signed_data
s 4 1 0 7fffffff 80000000 ffffffff fffffff0 80000000 12345678 c0000000 40000000
s 4 1 0 7fffffff 80000000 00000005 fffffff0 7fffffff edcba988 c0000000 40000000
s 4 1 0 7fffffff 80000000 fffffffd fffffff0 80000000 00000001 c0000000 40000000
s 4 1 0 7fffffff 80000000 00000002 fffffff0 7fffffff 00000000 c0000000 40000000
e 0 fffe00000000 0001fffffffc
e 1 ffffffffffc0 000000000003
e 2 000000000001 fffffffffffe
e 3 000100000000 ffff00000000
t length_change
s 4 1 0 00000001 00000010 00000002 00000020 00000003 00000030 00000004 00000040
s 5 1 0 00000001 00000010 00000002 00000020 00000003 00000030 00000004 00000040
s 5 1 0 00000001 00000010 00000002 00000020 00000003 00000030 00000004 00000040
s 5 1 0 00000001 00000010 00000002 00000020 00000003 00000030 00000004 00000040
e 0 000000000040 000000000004
e 1 000000000080 000000000008
e 2 0000000000c0 00000000000c
e 3 000000000100 000000000010
s 5 1 0 00000100 00000200 00000300 00000400 00000500 00000600 00000700 00000800
s 5 1 0 00000100 00000200 00000300 00000400 00000500 00000600 00000700 00000800
s 5 1 0 00000100 00000200 00000300 00000400 00000500 00000600 00000700 00000800
s 5 1 0 00000100 00000200 00000300 00000400 00000500 00000600 00000700 00000800
s 4 1 0 00000100 00000200 00000300 00000400 00000500 00000600 00000700 00000800
e 0 000000000a00 000000000500
e 1 000000001400 000000000f00
e 2 000000001e00 000000001900
e 3 000000002800 000000002300
t resync_mid_frame
s 4 1 0 11111111 11111111 11111111 11111111 11111111 11111111 11111111 11111111
s 4 1 0 11111111 11111111 11111111 11111111 11111111 11111111 11111111 11111111
s 4 1 1 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
s 4 1 0 00000001 00000002 00000003 00000004 00000005 00000006 00000007 00000008
s 4 1 0 00000001 00000002 00000003 00000004 00000005 00000006 00000007 00000008
s 4 1 0 00000001 00000002 00000003 00000004 00000005 00000006 00000007 00000008
s 4 1 0 00000001 00000002 00000003 00000004 00000005 00000006 00000007 00000008
e 0 000000000008 000000000004
e 1 000000000010 00000000000c
e 2 000000000018 000000000014
e 3 000000000020 00000000001c
t gate_control
s 4 0 0 55555555 55555555 55555555 55555555 55555555 55555555 55555555 55555555
s 4 0 0 55555555 55555555 55555555 55555555 55555555 55555555 55555555 55555555
s 4 0 0 55555555 55555555 55555555 55555555 55555555 55555555 55555555 55555555
s 4 0 0 55555555 55555555 55555555 55555555 55555555 55555555 55555555 55555555
s 4 1 0 0000000a 0000000b 0000000c 0000000d 0000000e 0000000f 00000010 00000011
s 4 1 0 0000000a 0000000b 0000000c 0000000d 0000000e 0000000f 00000010 00000011
s 4 1 0 0000000a 0000000b 0000000c 0000000d 0000000e 0000000f 00000010 00000011
s 4 1 0 0000000a 0000000b 0000000c 0000000d 0000000e 0000000f 00000010 00000011
e 0 00000000002c 000000000028
e 1 000000000034 000000000030
e 2 00000000003c 000000000038
e 3 000000000044 000000000040

/* sources.f */
hdl/ddc_pkg.sv
hdl/dump_timer.sv
hdl/iq_integrator.sv
hdl/channel_serializer.sv
hdl/ddc_readout.sv
bench/ddc_readout_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module ddc_readout_tb \
    --Mdir obj_dir \
    -o ddc_readout_sim \
    -f sources.f

sim_out="$(./obj_dir/ddc_readout_sim)"
echo "$sim_out"

if grep -qx "All checks passed" <<< "$sim_out"; then
    echo "Simulation result: pass"
    exit 0
fi

echo "Simulation result: fail"
exit 1
